// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tbCore
FLIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== common/coreDefs.sv ====
package coreDefs;

   parameter int XLen    = 32;
   parameter int RegIdxW = 5;

   typedef logic [XLen-1:0]    word_t;
   typedef logic [RegIdxW-1:0] regIdx_t;

   typedef enum logic [6:0] {
      OpImm    = 7'b0010011,
      OpReg    = 7'b0110011,
      OpLui    = 7'b0110111,
      OpJal    = 7'b1101111,
      OpBranch = 7'b1100011,
      OpLoad   = 7'b0000011,
      OpStore  = 7'b0100011,
      OpHalt   = 7'b1111111
   } opcode_t;

   // AluNe is the inverted compare used for BNE
   typedef enum logic [3:0] {
      AluAdd, AluSub, AluXor, AluOr, AluAnd, AluSlt, AluSltu,
      AluSll, AluSrl, AluSra, AluEq, AluNe
   } aluOp_t;

   // one instruction word read four ways
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         regIdx_t    rs2;
         regIdx_t    rs1;
         logic [2:0] funct3;
         regIdx_t    rd;
         opcode_t    opcode;
      } r;
      struct packed {
         logic [11:0] imm12;
         regIdx_t     rs1;
         logic [2:0]  funct3;
         regIdx_t     rd;
         opcode_t     opcode;
      } i;
      struct packed {
         logic [6:0] immHi;
         regIdx_t    rs2;
         regIdx_t    rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         opcode_t    opcode;
      } sb;
      struct packed {
         logic [19:0] imm20;
         regIdx_t     rd;
         opcode_t     opcode;
      } uj;
   } instr_u;

   parameter logic [2:0] F3Add  = 3'b000;
   parameter logic [2:0] F3Sll  = 3'b001;
   parameter logic [2:0] F3Slt  = 3'b010;
   parameter logic [2:0] F3Sltu = 3'b011;
   parameter logic [2:0] F3Xor  = 3'b100;
   parameter logic [2:0] F3Srl  = 3'b101;
   parameter logic [2:0] F3Or   = 3'b110;
   parameter logic [2:0] F3And  = 3'b111;
   parameter logic [2:0] F3Beq  = 3'b000;
   parameter logic [2:0] F3Bne  = 3'b001;
   parameter logic [2:0] F3Word = 3'b010;

   parameter logic [6:0] F7Base = 7'b0000000;
   parameter logic [6:0] F7Alt  = 7'b0100000;

endpackage

// ==== design/aluUnit.sv ====
module aluUnit (
   input  coreDefs::aluOp_t aluOp,
   input  coreDefs::word_t  opA,
   input  coreDefs::word_t  opB,
   output coreDefs::word_t  aluResult
);
   import coreDefs::*;

   logic [4:0] shamt;

   assign shamt = opB[4:0];

   always_comb begin
      case (aluOp)
         AluAdd:  aluResult = opA + opB;
         AluSub:  aluResult = opA - opB;
         AluXor:  aluResult = opA ^ opB;
         AluOr:   aluResult = opA | opB;
         AluAnd:  aluResult = opA & opB;
         AluSlt:  aluResult = word_t'($signed(opA) < $signed(opB));
         AluSltu: aluResult = word_t'(opA < opB);
         AluSll:  aluResult = opA << shamt;
         AluSrl:  aluResult = opA >> shamt;
         AluSra:  aluResult = $signed(opA) >>> shamt;
         AluEq:   aluResult = word_t'(opA == opB);
         AluNe:   aluResult = word_t'(opA != opB); // BNE
         default: aluResult = '0;
      endcase
   end

endmodule

// ==== design/coreCtrl.sv ====
module coreCtrl #(
   parameter int AddrWidth = 32
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   memVld,
   input  coreDefs::word_t        memRData,
   input  logic                   loadEn,
   input  coreDefs::word_t        aluResult,
   input  coreDefs::word_t        rdData2,
   input  coreDefs::regIdx_t      rd,
   input  coreDefs::word_t        imm,
   input  logic                   isLui,
   input  logic                   isJal,
   input  logic                   isBranch,
   input  logic                   isLoad,
   input  logic                   isStore,
   input  logic                   invalid,
   output logic                   memRdy,
   output logic                   memWEn,
   output logic [AddrWidth-1:0]   memAddr,
   output coreDefs::word_t        memWData,
   output logic                   halt,
   output coreDefs::instr_u       instr,
   output logic                   wrEn,
   output coreDefs::regIdx_t      wrIdx,
   output coreDefs::word_t        wrData
);
   import coreDefs::*;

   localparam logic [1:0] Fetch = 2'd0;
   localparam logic [1:0] Exec  = 2'd1;
   localparam logic [1:0] Mem   = 2'd2;

   logic [1:0]           state;
   logic [AddrWidth-1:0] pc;
   logic [AddrWidth-1:0] pcPlus1;
   logic [AddrWidth-1:0] target;
   logic                 takeJump;
   logic                 execWr;
   regIdx_t              ldRd;

   assign pcPlus1  = pc + 1'b1;
   assign target   = imm[AddrWidth-1:0]; // absolute, not pc relative
   assign takeJump = isJal || (isBranch && aluResult[0]);
   assign execWr   = !(isLoad || isStore || isBranch || invalid);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= Fetch;
         pc    <= '0;
         halt  <= 1'b1;
      end
      else if (halt) begin
         if (loadEn) begin
            halt  <= 1'b0;
            state <= Fetch;
         end
      end
      else begin
         case (state)
            Fetch: begin
               if (memVld) begin
                  state <= Exec;
               end
            end
            Exec: begin
               pc <= takeJump ? target : pcPlus1;
               if (invalid) begin // also opcode 7F
                  halt  <= 1'b1;
                  state <= Fetch;
               end
               else if (isLoad || isStore) begin
                  state <= Mem;
               end
               else begin
                  state <= Fetch;
               end
            end
            Mem: begin
               if (memVld) begin
                  state <= Fetch;
               end
            end
            default: state <= Fetch;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == Fetch && memVld) begin
         instr <= memRData;
      end
      if (state == Exec && isLoad) begin
         ldRd <= rd;
      end
   end

   // request levels held until memVld
   assign memRdy   = !halt && (state == Fetch || (state == Mem && isLoad));
   assign memWEn   = !halt && state == Mem && isStore;
   assign memAddr  = (state == Mem) ? aluResult[AddrWidth-1:0] : pc;
   assign memWData = rdData2;

   always_comb begin
      wrEn   = 1'b0;
      wrIdx  = rd;
      wrData = aluResult;
      if (state == Exec) begin
         wrEn = execWr;
         if (isLui) begin
            wrData = imm;
         end
         else if (isJal) begin
            wrData = word_t'(pcPlus1); // link
         end
      end
      else if (state == Mem) begin
         wrEn   = isLoad && memVld;
         wrIdx  = ldRd;
         wrData = memRData;
      end
   end

endmodule

// ==== design/instrDecode.sv ====
module instrDecode (
   input  coreDefs::instr_u  instr,
   output coreDefs::aluOp_t  aluOp,
   output coreDefs::regIdx_t rs1,
   output coreDefs::regIdx_t rs2,
   output coreDefs::regIdx_t rd,
   output coreDefs::word_t   imm,
   output logic              useImm,
   output logic              isLui,
   output logic              isJal,
   output logic              isBranch,
   output logic              isLoad,
   output logic              isStore,
   output logic              invalid
);
   import coreDefs::*;

   always_comb begin
      aluOp    = AluAdd;
      rs1      = '0;
      rs2      = '0;
      rd       = '0;
      imm      = '0;
      useImm   = 1'b0;
      isLui    = 1'b0;
      isJal    = 1'b0;
      isBranch = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      invalid  = 1'b0;

      case (instr.r.opcode)
         OpImm: begin
            rs1    = instr.i.rs1;
            rd     = instr.i.rd;
            useImm = 1'b1;
            imm    = {{(XLen-12){instr.i.imm12[11]}}, instr.i.imm12};
            case (instr.i.funct3)
               F3Add:  aluOp = AluAdd;
               F3Slt:  aluOp = AluSlt;
               F3Sltu: aluOp = AluSltu;
               F3Xor:  aluOp = AluXor;
               F3Or:   aluOp = AluOr;
               F3And:  aluOp = AluAnd;
               F3Sll: begin
                  aluOp   = AluSll;
                  imm     = word_t'(instr.i.imm12[4:0]); // shamt only
                  invalid = instr.r.funct7 != F7Base;
               end
               default: begin // F3Srl
                  imm     = word_t'(instr.i.imm12[4:0]);
                  aluOp   = (instr.r.funct7 == F7Alt) ? AluSra : AluSrl;
                  invalid = instr.r.funct7 != F7Base && instr.r.funct7 != F7Alt;
               end
            endcase
         end
         OpReg: begin
            rs1 = instr.r.rs1;
            rs2 = instr.r.rs2;
            rd  = instr.r.rd;
            if (instr.r.funct7 == F7Base) begin
               case (instr.r.funct3)
                  F3Add:   aluOp = AluAdd;
                  F3Sll:   aluOp = AluSll;
                  F3Slt:   aluOp = AluSlt;
                  F3Sltu:  aluOp = AluSltu;
                  F3Xor:   aluOp = AluXor;
                  F3Srl:   aluOp = AluSrl;
                  F3Or:    aluOp = AluOr;
                  default: aluOp = AluAnd;
               endcase
            end
            else if (instr.r.funct7 == F7Alt && instr.r.funct3 == F3Add) begin
               aluOp = AluSub;
            end
            else if (instr.r.funct7 == F7Alt && instr.r.funct3 == F3Srl) begin
               aluOp = AluSra;
            end
            else begin
               invalid = 1'b1;
            end
         end
         OpLui: begin
            rd    = instr.uj.rd;
            imm   = {instr.uj.imm20, 12'b0};
            isLui = 1'b1;
         end
         OpJal: begin
            rd    = instr.uj.rd;
            imm   = word_t'(instr.uj.imm20); // absolute word target
            isJal = 1'b1;
         end
         OpBranch: begin
            rs1      = instr.sb.rs1;
            rs2      = instr.sb.rs2;
            imm      = word_t'({instr.sb.immHi, instr.sb.immLo});
            isBranch = 1'b1;
            case (instr.sb.funct3)
               F3Beq:   aluOp = AluEq;
               F3Bne:   aluOp = AluNe;
               default: invalid = 1'b1;
            endcase
         end
         OpLoad: begin
            rs1     = instr.i.rs1;
            rd      = instr.i.rd;
            useImm  = 1'b1;
            imm     = {{(XLen-12){instr.i.imm12[11]}}, instr.i.imm12};
            isLoad  = 1'b1;
            invalid = instr.i.funct3 != F3Word;
         end
         OpStore: begin
            rs1     = instr.sb.rs1;
            rs2     = instr.sb.rs2;
            useImm  = 1'b1;
            imm     = {{(XLen-12){instr.sb.immHi[6]}}, instr.sb.immHi, instr.sb.immLo};
            isStore = 1'b1;
            invalid = instr.sb.funct3 != F3Word;
         end
         OpHalt:  invalid = 1'b1;
         default: invalid = 1'b1;
      endcase
   end

endmodule

// ==== design/lanzonesCore.sv ====
module lanzonesCore #(
   parameter int AddrWidth = 32
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 memVld,
   input  coreDefs::word_t      memRData,
   input  logic                 loadEn,
   output logic                 memRdy,
   output logic                 memWEn,
   output logic [AddrWidth-1:0] memAddr,
   output coreDefs::word_t      memWData,
   output logic                 halt
);
   import coreDefs::*;

   instr_u  instr;
   aluOp_t  aluOp;
   regIdx_t rs1;
   regIdx_t rs2;
   regIdx_t rd;
   regIdx_t wrIdx;
   word_t   imm;
   word_t   rdData1;
   word_t   rdData2;
   word_t   opB;
   word_t   aluResult;
   word_t   wrData;
   logic    wrEn;
   logic    useImm;
   logic    isLui;
   logic    isJal;
   logic    isBranch;
   logic    isLoad;
   logic    isStore;
   logic    invalid;

   assign opB = useImm ? imm : rdData2; // operand B select

   coreCtrl #(.AddrWidth(AddrWidth)) uCtrl (
      .clk(clk), .rstn(rstn), .memVld(memVld), .memRData(memRData), .loadEn(loadEn),
      .aluResult(aluResult), .rdData2(rdData2), .rd(rd), .imm(imm),
      .isLui(isLui), .isJal(isJal), .isBranch(isBranch), .isLoad(isLoad),
      .isStore(isStore), .invalid(invalid), .memRdy(memRdy), .memWEn(memWEn),
      .memAddr(memAddr), .memWData(memWData), .halt(halt), .instr(instr),
      .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData)
   );

   instrDecode uDec (
      .instr(instr), .aluOp(aluOp), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
      .useImm(useImm), .isLui(isLui), .isJal(isJal), .isBranch(isBranch),
      .isLoad(isLoad), .isStore(isStore), .invalid(invalid)
   );

   regFile uRegs (
      .clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .wrEn(wrEn), .wrIdx(wrIdx),
      .wrData(wrData), .rdData1(rdData1), .rdData2(rdData2)
   );

   aluUnit uAlu (
      .aluOp(aluOp), .opA(rdData1), .opB(opB), .aluResult(aluResult)
   );

endmodule

// ==== design/regFile.sv ====
module regFile (
   input  logic              clk,
   input  logic              rstn,
   input  coreDefs::regIdx_t rs1,
   input  coreDefs::regIdx_t rs2,
   input  logic              wrEn,
   input  coreDefs::regIdx_t wrIdx,
   input  coreDefs::word_t   wrData,
   output coreDefs::word_t   rdData1,
   output coreDefs::word_t   rdData2
);
   import coreDefs::*;

   word_t regs [1 << RegIdxW];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int k = 0; k < (1 << RegIdxW); k++) begin
            regs[k] <= '0;
         end
      end
      else if (wrEn && wrIdx != '0) begin // x0 never written
         regs[wrIdx] <= wrData;
      end
   end

   assign rdData1 = regs[rs1];
   assign rdData2 = regs[rs2];

endmodule

// ==== list.f ====
common/coreDefs.sv
design/regFile.sv
design/instrDecode.sv
design/aluUnit.sv
design/coreCtrl.sv
design/lanzonesCore.sv
sim/tbCore.sv

// ==== sim/tbCore.sv ====
module tbCore;
   import coreDefs::*;

   localparam int AddrWidth = 32;
   localparam int Period    = 40;
   localparam int NumProgs  = 3;
   localparam int MaxInstr  = 64;
   localparam int MemWords  = 1024;
   localparam int DataBase  = 'h200;
   localparam int DataWords = 64;
   localparam int InitRegs  = 6;
   localparam int BodyLen   = 40;

   logic                 clk;
   logic                 rstn;
   logic                 memVld;
   logic                 loadEn;
   word_t                memRData;
   logic                 memRdy;
   logic                 memWEn;
   logic [AddrWidth-1:0] memAddr;
   word_t                memWData;
   logic                 halt;

   word_t mem [MemWords];    // memory seen by the DUT
   word_t refMem [MemWords]; // model copy
   word_t refRegs [32];
   int    refPc;
   integer seed;

   // expected bus requests, in order
   logic                 expWr [$];
   logic [AddrWidth-1:0] expAddr [$];
   word_t                expData [$];

   lanzonesCore #(.AddrWidth(AddrWidth)) DUT (
      .clk(clk), .rstn(rstn), .memVld(memVld), .memRData(memRData), .loadEn(loadEn),
      .memRdy(memRdy), .memWEn(memWEn), .memAddr(memAddr), .memWData(memWData),
      .halt(halt)
   );

   initial begin
      clk = 1'b0;
      forever #(Period / 2) clk = ~clk;
   end

   initial begin
      #((NumProgs * MaxInstr * 12 + 100) * Period); // worst case per instruction
      stopRun("timeout: the core did not finish its programs");
   end

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         stopRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic checkAddr(input string name, input logic [AddrWidth-1:0] exp,
                            input logic [AddrWidth-1:0] act);
      if (act !== exp) begin
         stopRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stopRun($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
      end
   endtask

   function automatic int pick(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic word_t encR(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OpReg};
   endfunction

   function automatic word_t encI(input logic [11:0] imm, input int rs1,
                                  input logic [2:0] f3, input int rd, input opcode_t op);
      return {imm, 5'(rs1), f3, 5'(rd), op};
   endfunction

   // store and branch share the split immediate
   function automatic word_t encS(input logic [11:0] imm, input int rs2, input int rs1,
                                  input logic [2:0] f3, input opcode_t op);
      return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], op};
   endfunction

   function automatic word_t encU(input logic [19:0] imm, input int rd, input opcode_t op);
      return {imm, 5'(rd), op};
   endfunction

   task automatic genProgram(input int start, input logic endInvalid);
      int         pc;
      int         haltAt;
      int         rd;
      int         lastRd;
      int         target;
      logic [2:0] f3;
      logic [6:0] f7;
      pc     = start;
      haltAt = start + 1 + 2 * InitRegs + BodyLen;
      mem[pc++] = encI(12'(DataBase), 0, F3Add, 1, OpImm); // x1 is the data base
      for (int r = 2; r < 2 + InitRegs; r++) begin
         mem[pc++] = encU(20'($random(seed)), r, OpLui);
         mem[pc++] = encI(12'($random(seed)), r, F3Add, r, OpImm);
      end
      lastRd = 2;
      for (int k = 0; k < BodyLen; k++) begin
         rd     = 2 + pick(30);
         target = pc + 1 + pick(4); // forward only
         if (target > haltAt) begin
            target = haltAt;
         end
         f3 = 3'(pick(8));
         f7 = (pick(2) == 1) ? F7Alt : F7Base;
         if (k % 4 == 3) begin
            mem[pc] = encS(12'(pick(DataWords)), lastRd, 1, F3Word, OpStore);
         end
         else begin
            case (pick(6))
               0: begin
                  if (f3 != F3Add && f3 != F3Srl) begin
                     f7 = F7Base;
                  end
                  mem[pc] = encR(f7, pick(32), pick(32), f3, rd);
               end
               1: begin
                  if (f3 == F3Sll) begin
                     mem[pc] = encI({7'b0, 5'(pick(32))}, pick(32), f3, rd, OpImm);
                  end
                  else if (f3 == F3Srl) begin
                     mem[pc] = encI({f7, 5'(pick(32))}, pick(32), f3, rd, OpImm);
                  end
                  else begin
                     mem[pc] = encI(12'($random(seed)), pick(32), f3, rd, OpImm);
                  end
               end
               2: mem[pc] = encU(20'($random(seed)), rd, OpLui);
               3: mem[pc] = encI(12'(pick(DataWords)), 1, F3Word, rd, OpLoad);
               4: mem[pc] = encS(12'(target), pick(32), pick(32),
                                 (pick(2) == 1) ? F3Bne : F3Beq, OpBranch);
               default: mem[pc] = encU(20'(target), rd, OpJal);
            endcase
            lastRd = rd;
         end
         pc++;
      end
      if (endInvalid) begin
         mem[pc] = encR(7'b0000001, pick(32), pick(32), F3Add, 2 + pick(30)); // bad funct7
      end
      else begin
         mem[pc] = {25'b0, OpHalt};
      end
   endtask

   task automatic pushReq(input logic wr, input logic [AddrWidth-1:0] addr, input word_t data);
      expWr.push_back(wr);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   // instruction set model from refPc up to the halting instruction
   task automatic runModel();
      word_t      w;
      word_t      a;
      word_t      b;
      word_t      res;
      word_t      addr;
      logic [2:0] f3;
      logic [6:0] f7;
      int         nextPc;
      logic       done;
      logic       wrRd;
      done = 1'b0;
      while (!done) begin
         w      = refMem[refPc];
         f3     = w[14:12];
         f7     = w[31:25];
         a      = refRegs[w[19:15]];
         b      = refRegs[w[24:20]];
         nextPc = refPc + 1;
         wrRd   = 1'b1;
         res    = '0;
         pushReq(1'b0, AddrWidth'(refPc), '0); // fetch
         case (w[6:0])
            OpReg, OpImm: begin
               if (w[6:0] == OpImm) begin
                  b = {{20{w[31]}}, w[31:20]};
               end
               else if (f7 != F7Base && !(f7 == F7Alt && (f3 == F3Add || f3 == F3Srl))) begin
                  done = 1'b1;
               end
               case (f3)
                  F3Add:   res = (w[6:0] == OpReg && w[30]) ? a - b : a + b;
                  F3Sll:   res = a << b[4:0];
                  F3Slt:   res = word_t'($signed(a) < $signed(b));
                  F3Sltu:  res = word_t'(a < b);
                  F3Xor:   res = a ^ b;
                  F3Srl: begin
                     res = a >> b[4:0];
                     if (w[30]) begin
                        res = $signed(a) >>> b[4:0]; // arithmetic
                     end
                  end
                  F3Or:    res = a | b;
                  default: res = a & b;
               endcase
            end
            OpLui: res = {w[31:12], 12'b0};
            OpJal: begin
               res    = word_t'(refPc + 1);
               nextPc = int'(w[31:12]);
            end
            OpBranch: begin
               wrRd = 1'b0;
               if ((a == b) == (f3 == F3Beq)) begin
                  nextPc = int'({w[31:25], w[11:7]});
               end
            end
            OpLoad: begin
               addr = a + {{20{w[31]}}, w[31:20]};
               pushReq(1'b0, AddrWidth'(addr), '0);
               res = refMem[addr];
            end
            OpStore: begin
               addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
               pushReq(1'b1, AddrWidth'(addr), b);
               refMem[addr] = b;
               wrRd = 1'b0;
            end
            default: done = 1'b1; // 7F lands here
         endcase
         if (wrRd && !done && w[11:7] != 5'd0) begin
            refRegs[w[11:7]] = res;
         end
         refPc = nextPc;
      end
   endtask

   // memory model answering each request after 1 to 4 cycles
   task automatic serveBus(input string name);
      logic [AddrWidth-1:0] addr;
      logic                 wr;
      int                   delay;
      while (halt !== 1'b1) begin
         if (memRdy === 1'b1 || memWEn === 1'b1) begin
            if (expWr.size() == 0) begin
               stopRun({name, ": bus request after the program should have halted"});
            end
            checkFlag({name, " write request"}, expWr[0], memWEn);
            checkFlag({name, " read request"}, !expWr[0], memRdy);
            checkAddr({name, " address"}, expAddr[0], memAddr);
            if (expWr[0]) begin
               checkWord({name, " store data"}, expData[0], memWData);
            end
            void'(expWr.pop_front());
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            addr  = memAddr;
            wr    = memWEn;
            delay = 1 + pick(4);
            repeat (delay - 1) begin
               @(negedge clk);
               checkFlag({name, " request held"}, 1'b1, wr ? memWEn : memRdy);
               checkAddr({name, " address held"}, addr, memAddr);
            end
            if (addr >= MemWords) begin
               stopRun({name, ": request address is outside the memory"});
            end
            if (wr) begin
               mem[addr] = memWData;
            end
            else begin
               memRData = mem[addr];
            end
            memVld = 1'b1;
            @(negedge clk);
            memVld = 1'b0;
         end
         else begin
            @(negedge clk);
         end
      end
   endtask

   task automatic checkIdle(input string name, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         checkFlag({name, " halt"}, 1'b1, halt);
         checkFlag({name, " memRdy while halted"}, 1'b0, memRdy);
         checkFlag({name, " memWEn while halted"}, 1'b0, memWEn);
      end
   endtask

   initial begin
      string name;
      seed     = 32'hf2bb;
      rstn     = 1'b0;
      memVld   = 1'b0;
      memRData = '0;
      loadEn   = 1'b0;
      for (int k = 0; k < MemWords; k++) begin
         mem[k] = $random(seed);
      end
      // each program starts where the previous one halted
      for (int p = 0; p < NumProgs; p++) begin
         genProgram(p * (2 + 2 * InitRegs + BodyLen), p == NumProgs - 1);
      end
      refMem = mem;
      for (int r = 0; r < 32; r++) begin
         refRegs[r] = '0;
      end
      refPc = 0;

      repeat (10) @(negedge clk);
      rstn = 1'b1;
      checkIdle("after reset", 20);

      for (int p = 0; p < NumProgs; p++) begin
         name = $sformatf("prog%0d", p);
         runModel();
         @(negedge clk);
         loadEn = 1'b1;
         @(negedge clk);
         loadEn = 1'b0;
         serveBus(name);
         checkWord({name, " requests left"}, '0, word_t'(expWr.size()));
         checkIdle({name, " after halt"}, 10);
      end

      $display("Testbench passed");
      $finish;
   end

endmodule
